// ==== hw/rename_pkg.sv ====
`default_nettype none

package rename_pkg;

    localparam int REG_ADDR_LEN = 5;
    localparam int REG_LEN      = 1 << REG_ADDR_LEN;
    localparam int ROB_TAG_LEN  = 3;
    localparam int DATA_LEN     = 32;

    typedef logic [REG_ADDR_LEN-1:0] reg_addr_t;
    typedef logic [ROB_TAG_LEN-1:0]  rob_tag_t;
    typedef logic [DATA_LEN-1:0]     data_t;

    // All ones is never handed out as a ROB index.
    localparam rob_tag_t NO_TAG = '1;

    // Where a source operand currently lives.
    typedef enum logic [1:0] {
        DS_ARCH      = 2'b00, // Architectural register file.
        DS_ROB_WAIT  = 2'b10, // Producer still in flight.
        DS_ROB_READY = 2'b11  // Result parked in the ROB.
    } data_stat_e;

    typedef struct packed {
        rob_tag_t rob_tag;      // Newest in-flight writer.
        logic     ready_in_rob; // Writer has completed on the CDB.
    } map_entry_t;

    typedef struct packed {
        reg_addr_t dest;
        reg_addr_t src1;
        reg_addr_t src2;
    } arch_reg_t;

    typedef struct packed {
        data_stat_e data_stat;
        reg_addr_t  reg_addr;
        rob_tag_t   rob_tag;
    } src_operand_t;

    typedef struct packed {
        src_operand_t src1;
        src_operand_t src2;
        reg_addr_t    dest;
        rob_tag_t     rob_tag; // Tag allocated to this instruction.
    } renamed_pack_t;

    typedef struct packed {
        rob_tag_t rob_tag;
        data_t    value;
    } cdb_t;

    typedef struct packed {
        reg_addr_t reg_addr;
        rob_tag_t  rob_tag;
        data_t     value;
    } commit_t;

endpackage

`default_nettype wire

// ==== hw/map_table.sv ====
`timescale 1ns/1ns
`default_nettype none

module map_table import rename_pkg::*; (
    input  logic          clk,
    input  logic          reset,
    input  arch_reg_t     arch_reg,
    input  logic          assign_flag,
    input  rob_tag_t      assign_rob_tag,
    input  logic          return_flag,
    input  reg_addr_t     reg_addr_from_rob,
    input  rob_tag_t      rob_tag_from_rob,
    input  logic          ready_flag,
    input  reg_addr_t     reg_addr_from_cdb,
    input  rob_tag_t      rob_tag_from_cdb,
    output renamed_pack_t renamed_pack
);

    map_entry_t table_q [REG_LEN];
    map_entry_t table_d [REG_LEN];

    // Classify one source against its map entry.
    function automatic src_operand_t lookup(input reg_addr_t addr, input map_entry_t entry);
        src_operand_t op;
        op.reg_addr = addr;
        if (entry.rob_tag == NO_TAG) begin
            op.data_stat = DS_ARCH;
            op.rob_tag   = NO_TAG;
        end else if (entry.ready_in_rob) begin
            op.data_stat = DS_ROB_READY;
            op.rob_tag   = entry.rob_tag;
        end else begin
            op.data_stat = DS_ROB_WAIT;
            op.rob_tag   = entry.rob_tag;
        end
        return op;
    endfunction

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < REG_LEN; i++) begin
                table_q[i].rob_tag      <= NO_TAG;
                table_q[i].ready_in_rob <= 1'b0;
            end
        end else begin
            table_q <= table_d;
        end
    end

    // Updates are applied in turn, each one seeing the result of the one before.
    always_comb begin
        table_d = table_q;

        if (assign_flag) begin
            table_d[arch_reg.dest].rob_tag      = assign_rob_tag;
            table_d[arch_reg.dest].ready_in_rob = 1'b0;
        end

        // Only the newest writer may release the register.
        if (return_flag && table_d[reg_addr_from_rob].rob_tag == rob_tag_from_rob) begin
            table_d[reg_addr_from_rob].rob_tag      = NO_TAG;
            table_d[reg_addr_from_rob].ready_in_rob = 1'b0;
        end

        // A result for an overwritten tag is ignored.
        if (ready_flag && table_d[reg_addr_from_cdb].rob_tag == rob_tag_from_cdb) begin
            table_d[reg_addr_from_cdb].ready_in_rob = 1'b1;
        end
    end

    // Lookups see the table as it was before this cycle's updates.
    assign renamed_pack.src1    = lookup(arch_reg.src1, table_q[arch_reg.src1]);
    assign renamed_pack.src2    = lookup(arch_reg.src2, table_q[arch_reg.src2]);
    assign renamed_pack.dest    = arch_reg.dest;
    assign renamed_pack.rob_tag = assign_rob_tag;

    // The ROB must never allocate the reserved tag.
    a_assign_tag_valid: assert property (
        @(posedge clk) disable iff (reset)
        assign_flag |-> assign_rob_tag != NO_TAG
    ) else $error("map_table: NO_TAG allocated to r%0d", arch_reg.dest);

endmodule

`default_nettype wire

// ==== hw/reorder_buffer.sv ====
`timescale 1ns/1ns
`default_nettype none

module reorder_buffer import rename_pkg::*; #(
    parameter int rob_depth = 7
) (
    input  logic      clk,
    input  logic      reset,
    input  logic      dispatch_valid,
    input  reg_addr_t dest,
    input  logic      cdb_valid,
    input  cdb_t      cdb,
    output logic      dispatch_ready,
    output logic      alloc_fire,
    output rob_tag_t  alloc_tag,
    output logic      ready_flag,
    output reg_addr_t ready_reg,
    output rob_tag_t  ready_tag,
    output logic      commit_valid,
    output commit_t   commit
);

    localparam rob_tag_t               last_tag    = rob_tag_t'(rob_depth - 1);
    localparam logic [ROB_TAG_LEN:0] depth_count = (ROB_TAG_LEN + 1)'(rob_depth);

    reg_addr_t dest_q  [rob_depth];
    data_t     value_q [rob_depth];
    logic [rob_depth-1:0] done_q;

    rob_tag_t head;
    rob_tag_t tail;
    logic [ROB_TAG_LEN:0] count;

    logic [ROB_TAG_LEN:0] cdb_offset;
    logic                 cdb_in_window;

    function automatic rob_tag_t next_ptr(input rob_tag_t ptr);
        return (ptr == last_tag) ? '0 : ptr + 1'b1;
    endfunction

    assign dispatch_ready = (count != depth_count);
    assign alloc_fire     = dispatch_valid && dispatch_ready;
    assign alloc_tag      = tail; // Tag is the entry index.

    // Completion is forwarded so the map table can mark the register ready.
    assign ready_flag = cdb_valid;
    assign ready_reg  = dest_q[cdb.rob_tag];
    assign ready_tag  = cdb.rob_tag;

    // Done is cleared on retire, so an empty head never looks done.
    assign commit_valid    = done_q[head];
    assign commit.reg_addr = dest_q[head];
    assign commit.rob_tag  = head;
    assign commit.value    = value_q[head];

    always_ff @(posedge clk) begin
        if (reset) begin
            head   <= '0;
            tail   <= '0;
            count  <= '0;
            done_q <= '0;
        end else begin
            if (alloc_fire) begin
                tail         <= next_ptr(tail);
                done_q[tail] <= 1'b0;
            end
            if (cdb_valid) begin
                done_q[cdb.rob_tag] <= 1'b1;
            end
            if (commit_valid) begin
                head         <= next_ptr(head);
                done_q[head] <= 1'b0;
            end
            case ({alloc_fire, commit_valid})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (alloc_fire) begin
            dest_q[tail] <= dest;
        end
        if (cdb_valid) begin
            value_q[cdb.rob_tag] <= cdb.value;
        end
    end

    // Distance of the CDB tag from head, modulo the ring size.
    always_comb begin
        if (cdb.rob_tag >= head) begin
            cdb_offset = {1'b0, cdb.rob_tag - head};
        end else begin
            cdb_offset = {1'b0, cdb.rob_tag} + depth_count - {1'b0, head};
        end
        cdb_in_window = (cdb.rob_tag <= last_tag) && (cdb_offset < count);
    end

    a_no_dispatch_when_full: assert property (
        @(posedge clk) disable iff (reset)
        dispatch_valid |-> dispatch_ready
    ) else $error("reorder_buffer: dispatch while full");

    // Each in-flight tag completes exactly once.
    a_cdb_tag_outstanding: assert property (
        @(posedge clk) disable iff (reset)
        cdb_valid |-> cdb_in_window && !done_q[cdb.rob_tag]
    ) else $error("reorder_buffer: CDB tag %0d not outstanding", cdb.rob_tag);

    a_depth_fits: assert property (
        @(posedge clk) rob_depth > 0 && rob_depth < (1 << ROB_TAG_LEN)
    ) else $error("reorder_buffer: rob_depth %0d collides with NO_TAG", rob_depth);

endmodule

`default_nettype wire

// ==== hw/rename_stage.sv ====
`timescale 1ns/1ns
`default_nettype none

module rename_stage import rename_pkg::*; #(
    parameter int rob_depth = 7
) (
    input  logic          clk,
    input  logic          reset,
    input  logic          dispatch_valid,
    input  arch_reg_t     arch_reg,
    input  logic          cdb_valid,
    input  cdb_t          cdb,
    output logic          dispatch_ready,
    output renamed_pack_t renamed_pack,
    output logic          commit_valid,
    output commit_t       commit
);

    logic      alloc_fire;
    rob_tag_t  alloc_tag;
    logic      ready_flag;
    reg_addr_t ready_reg;
    rob_tag_t  ready_tag;

    map_table u_map_table (
        .clk               (clk),
        .reset             (reset),
        .arch_reg          (arch_reg),
        .assign_flag       (alloc_fire),
        .assign_rob_tag    (alloc_tag),
        .return_flag       (commit_valid), // Retire releases the mapping.
        .reg_addr_from_rob (commit.reg_addr),
        .rob_tag_from_rob  (commit.rob_tag),
        .ready_flag        (ready_flag),
        .reg_addr_from_cdb (ready_reg),
        .rob_tag_from_cdb  (ready_tag),
        .renamed_pack      (renamed_pack)
    );

    reorder_buffer #(
        .rob_depth (rob_depth)
    ) u_reorder_buffer (
        .clk            (clk),
        .reset          (reset),
        .dispatch_valid (dispatch_valid),
        .dest           (arch_reg.dest),
        .cdb_valid      (cdb_valid),
        .cdb            (cdb),
        .dispatch_ready (dispatch_ready),
        .alloc_fire     (alloc_fire),
        .alloc_tag      (alloc_tag),
        .ready_flag     (ready_flag),
        .ready_reg      (ready_reg),
        .ready_tag      (ready_tag),
        .commit_valid   (commit_valid),
        .commit         (commit)
    );

endmodule

`default_nettype wire

// ==== testbench/tb_clock.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_clock #(
    parameter int period_ns    = 100,
    parameter int reset_cycles = 5
) (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #(period_ns / 2) clk = ~clk;
    end

    initial begin
        reset = 1'b1;
        repeat (reset_cycles) @(posedge clk);
        reset <= 1'b0; // Released on a rising edge like the rest of the stimulus.
    end

endmodule

`default_nettype wire

// ==== testbench/rename_stage_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module rename_stage_tb import rename_pkg::*; ();

    localparam int clk_period_ns   = 100;
    localparam int reset_cycles    = 5;
    localparam int rob_depth       = 7;
    localparam int sweep_cycles    = REG_LEN / 2;
    localparam int directed_cycles = 80;
    localparam int random_cycles   = 300;
    localparam int drain_limit     = 40;
    localparam int total_cycles    = reset_cycles + sweep_cycles + directed_cycles
                                     + random_cycles + 3 * drain_limit;
    localparam int timeout_ns      = 2 * total_cycles * clk_period_ns + 10 * clk_period_ns;

    logic          clk;
    logic          reset;
    logic          dispatch_valid;
    arch_reg_t     arch_reg;
    logic          cdb_valid;
    cdb_t          cdb;
    logic          dispatch_ready;
    renamed_pack_t renamed_pack;
    logic          commit_valid;
    commit_t       commit;

    // Reference model of the map table and the reorder buffer.
    int        map_tag   [REG_LEN]; // -1 when no writer is in flight.
    logic      map_ready [REG_LEN];
    reg_addr_t rob_dest  [rob_depth];
    data_t     rob_value [rob_depth];
    logic      rob_done  [rob_depth];
    int        head;
    int        tail;
    int        count;

    int unsigned seed = 94;
    string       test_name = "reset";

    tb_clock #(
        .period_ns    (clk_period_ns),
        .reset_cycles (reset_cycles)
    ) u_clock (
        .clk   (clk),
        .reset (reset)
    );

    rename_stage #(
        .rob_depth (rob_depth)
    ) dut (
        .clk            (clk),
        .reset          (reset),
        .dispatch_valid (dispatch_valid),
        .arch_reg       (arch_reg),
        .cdb_valid      (cdb_valid),
        .cdb            (cdb),
        .dispatch_ready (dispatch_ready),
        .renamed_pack   (renamed_pack),
        .commit_valid   (commit_valid),
        .commit         (commit)
    );

    task automatic end_with_failure();
        $display(">>> FAIL");
        $fatal(1, "rename_stage_tb stopped at the first failure");
    endtask

    task automatic abort_run(input string reason);
        $display("%s", reason);
        end_with_failure();
    endtask

    task automatic report_mismatch(input string what, input logic [63:0] expected,
                                   input logic [63:0] actual);
        $display("Error: test %s, %s: expected 0x%0h, actual 0x%0h",
                 test_name, what, expected, actual);
        end_with_failure();
    endtask

    task automatic check_value(input string what, input logic [63:0] expected,
                               input logic [63:0] actual);
        assert (actual === expected) else report_mismatch(what, expected, actual);
    endtask

    function automatic int unsigned next_random();
        seed = seed * 32'd1103515245 + 32'd12345;
        return seed;
    endfunction

    function automatic int pick(input int n);
        return int'((next_random() >> 16) % n); // The low bits of an LCG repeat quickly.
    endfunction

    function automatic src_operand_t expected_src(input reg_addr_t addr);
        src_operand_t op;
        op.reg_addr  = addr;
        op.rob_tag   = NO_TAG;
        op.data_stat = DS_ARCH;
        if (map_tag[addr] >= 0) begin
            op.rob_tag   = rob_tag_t'(map_tag[addr]);
            op.data_stat = map_ready[addr] ? DS_ROB_READY : DS_ROB_WAIT;
        end
        return op;
    endfunction

    task automatic reset_model();
        for (int r = 0; r < REG_LEN; r++) begin
            map_tag[r]   = -1;
            map_ready[r] = 1'b0;
        end
        for (int i = 0; i < rob_depth; i++) begin
            rob_dest[i]  = '0;
            rob_value[i] = '0;
            rob_done[i]  = 1'b0;
        end
        head  = 0;
        tail  = 0;
        count = 0;
    endtask

    task automatic check_outputs();
        commit_t expected_commit;
        logic    expected_commit_valid;
        expected_commit_valid = (count != 0) && rob_done[head];
        check_value("dispatch_ready", 64'(count != rob_depth), 64'(dispatch_ready));
        check_value("commit_valid", 64'(expected_commit_valid), 64'(commit_valid));
        if (expected_commit_valid) begin
            expected_commit.reg_addr = rob_dest[head];
            expected_commit.rob_tag  = rob_tag_t'(head);
            expected_commit.value    = rob_value[head];
            check_value("commit", 64'(expected_commit), 64'(commit));
        end
        check_value("src1", 64'(expected_src(arch_reg.src1)), 64'(renamed_pack.src1));
        check_value("src2", 64'(expected_src(arch_reg.src2)), 64'(renamed_pack.src2));
        check_value("dest", 64'(arch_reg.dest), 64'(renamed_pack.dest));
        if (dispatch_valid) begin
            check_value("allocated tag", 64'(rob_tag_t'(tail)), 64'(renamed_pack.rob_tag));
        end
    endtask

    // Moves the model to the state after the coming rising edge.
    task automatic advance_model();
        logic      fire;
        logic      retire;
        reg_addr_t retire_reg;
        reg_addr_t done_reg;
        int        done_tag;
        fire       = dispatch_valid && (count != rob_depth);
        retire     = (count != 0) && rob_done[head];
        retire_reg = rob_dest[head];
        done_tag   = 0;
        done_reg   = '0;
        if (cdb_valid) begin
            done_tag = int'(cdb.rob_tag);
            done_reg = rob_dest[done_tag];
        end
        if (fire) begin // Assign, then return, then ready.
            map_tag[arch_reg.dest]   = tail;
            map_ready[arch_reg.dest] = 1'b0;
        end
        if (retire && map_tag[retire_reg] == head) begin
            map_tag[retire_reg]   = -1;
            map_ready[retire_reg] = 1'b0;
        end
        if (cdb_valid && map_tag[done_reg] == done_tag) begin
            map_ready[done_reg] = 1'b1;
        end
        if (fire) begin
            rob_dest[tail] = arch_reg.dest;
            rob_done[tail] = 1'b0;
            tail           = (tail + 1) % rob_depth;
        end
        if (cdb_valid) begin
            rob_done[done_tag]  = 1'b1;
            rob_value[done_tag] = cdb.value;
        end
        if (retire) begin
            rob_done[head] = 1'b0;
            head           = (head + 1) % rob_depth;
        end
        count = count + (fire ? 1 : 0) - (retire ? 1 : 0);
    endtask

    always @(negedge clk) begin
        if (reset !== 1'b0) begin
            reset_model();
        end else begin
            check_outputs();
            advance_model();
        end
    end

    task automatic apply(input logic dv, input reg_addr_t dest, input reg_addr_t src1,
                         input reg_addr_t src2, input logic cv, input rob_tag_t ctag);
        arch_reg_t regs;
        cdb_t      result;
        regs.dest      = dest;
        regs.src1      = src1;
        regs.src2      = src2;
        result.rob_tag = ctag;
        result.value   = data_t'(next_random());
        dispatch_valid <= dv && (count != rob_depth); // Never offer into a full buffer.
        arch_reg       <= regs;
        cdb_valid      <= cv;
        cdb            <= result;
    endtask

    task automatic step(input logic dv, input reg_addr_t dest, input reg_addr_t src1,
                        input reg_addr_t src2, input logic cv, input rob_tag_t ctag);
        @(posedge clk);
        apply(dv, dest, src1, src2, cv, ctag);
    endtask

    // Picks an outstanding tag that has not completed yet.
    task automatic pick_pending(output logic found, output rob_tag_t tag);
        int pending [$];
        int idx;
        for (int k = 0; k < count; k++) begin
            idx = (head + k) % rob_depth;
            if (!rob_done[idx]) begin
                pending.push_back(idx);
            end
        end
        found = (pending.size() != 0);
        tag   = '0;
        if (found) begin
            tag = rob_tag_t'(pending[pick(pending.size())]);
        end
    endtask

    task automatic random_step(input int dispatch_pct, input int cdb_pct);
        logic      dv;
        logic      cv;
        logic      found;
        rob_tag_t  tag;
        reg_addr_t dest;
        reg_addr_t src1;
        reg_addr_t src2;
        @(posedge clk);
        dv   = pick(100) < dispatch_pct;
        dest = reg_addr_t'(pick(8)); // Small pool so writers collide.
        src1 = reg_addr_t'(pick(8));
        src2 = reg_addr_t'(pick(8));
        pick_pending(found, tag);
        cv = found && (pick(100) < cdb_pct);
        apply(dv, dest, src1, src2, cv, tag);
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        while (count != 0) begin
            if (waited == drain_limit) begin
                abort_run("Reorder buffer did not drain in time");
            end else begin
                random_step(0, 100);
                waited++;
            end
        end
    endtask

    initial begin
        #(timeout_ns);
        abort_run("Watchdog expired before the tests finished");
    end

    initial begin
        int bp_base;
        dispatch_valid <= 1'b0;
        arch_reg       <= '0;
        cdb_valid      <= 1'b0;
        cdb            <= '0;
        @(negedge reset);

        for (int i = 0; i < sweep_cycles; i++) begin
            step(1'b0, '0, reg_addr_t'(2 * i), reg_addr_t'(2 * i + 1), 1'b0, '0);
        end

        test_name = "rename";
        step(1'b1, 5'd3, 5'd3, 5'd4, 1'b0, 3'd0); // Tag 0 to r3.
        step(1'b1, 5'd5, 5'd3, 5'd3, 1'b0, 3'd0); // Tag 1 to r5.
        step(1'b1, 5'd3, 5'd3, 5'd5, 1'b0, 3'd0); // Tag 2 overwrites r3.
        step(1'b0, 5'd0, 5'd3, 5'd5, 1'b0, 3'd0);

        test_name = "complete";
        step(1'b0, 5'd0, 5'd3, 5'd5, 1'b1, 3'd0); // Stale tag of r3.
        step(1'b0, 5'd0, 5'd3, 5'd5, 1'b1, 3'd1);
        step(1'b0, 5'd0, 5'd3, 5'd5, 1'b0, 3'd0);
        step(1'b0, 5'd0, 5'd3, 5'd5, 1'b0, 3'd0);

        test_name = "retire";
        step(1'b0, 5'd0, 5'd3, 5'd5, 1'b1, 3'd2);
        step(1'b1, 5'd6, 5'd6, 5'd3, 1'b0, 3'd0); // Takes tags 3 to 6.
        step(1'b1, 5'd7, 5'd6, 5'd7, 1'b0, 3'd0);
        step(1'b1, 5'd6, 5'd6, 5'd7, 1'b0, 3'd0);
        step(1'b1, 5'd8, 5'd6, 5'd8, 1'b0, 3'd0);
        step(1'b0, 5'd0, 5'd6, 5'd8, 1'b1, 3'd6); // Out of program order.
        step(1'b0, 5'd0, 5'd6, 5'd8, 1'b1, 3'd4);
        step(1'b0, 5'd0, 5'd7, 5'd6, 1'b1, 3'd5);
        step(1'b0, 5'd0, 5'd6, 5'd7, 1'b1, 3'd3);
        repeat (4) step(1'b0, 5'd0, 5'd6, 5'd8, 1'b0, 3'd0);
        drain();

        test_name = "backpressure";
        bp_base = tail;
        for (int i = 0; i < rob_depth + 2; i++) begin
            step(1'b1, reg_addr_t'(9 + i), reg_addr_t'(9 + i), 5'd9, 1'b0, 3'd0);
        end
        step(1'b0, 5'd0, 5'd9, 5'd12, 1'b1, rob_tag_t'((bp_base + 3) % rob_depth));
        step(1'b0, 5'd0, 5'd9, 5'd12, 1'b1, rob_tag_t'(bp_base));
        step(1'b0, 5'd0, 5'd9, 5'd12, 1'b0, 3'd0);
        step(1'b1, 5'd20, 5'd9, 5'd20, 1'b0, 3'd0); // Room again after the commit.
        drain();

        test_name = "random";
        repeat (random_cycles) random_step(60, 50);
        test_name = "drain";
        drain();
        step(1'b0, 5'd0, 5'd0, 5'd1, 1'b0, 3'd0);
        repeat (2) @(posedge clk);
        $display(">>> PASS");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog.f ====
hw/rename_pkg.sv
hw/map_table.sv
hw/reorder_buffer.sv
hw/rename_stage.sv
testbench/tb_clock.sv
testbench/rename_stage_tb.sv

// ==== Makefile ====
# Verilator build and run of the rename stage testbench.

TOP := rename_stage_tb

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"

test:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f verilog.f -o $(TOP)
	./obj_dir/$(TOP)

clean:
	rm -rf obj_dir
